// ==== hdl/alu_pkg.sv ====
// ********************
// Opcode numbers follow the legacy soft-core ALU map
// Floating-point codes are gone and now decode as invalid
// ********************

package alu_pkg;

	// ******************** Widths
	localparam int OP_BITS       = 6;  // Opcode field width
	localparam int DEFAULT_WIDTH = 32; // Datapath width unless overridden

	// ******************** Opcodes
	// Gaps in the numbering belong to the dropped float operations
	typedef enum logic [OP_BITS-1:0] {
		OP_NOP   = 6'd0,  // Pass accumulator
		OP_LOD   = 6'd1,  // Pass memory operand
		OP_ADD   = 6'd2,
		OP_MLT   = 6'd4,
		OP_DIV   = 6'd6,
		OP_MOD   = 6'd8,
		OP_SGN   = 6'd9,
		OP_NEG   = 6'd11,
		OP_NEG_M = 6'd12,
		OP_ABS   = 6'd15,
		OP_ABS_M = 6'd16,
		OP_PST   = 6'd19,
		OP_PST_M = 6'd20,
		OP_NRM   = 6'd23,
		OP_NRM_M = 6'd24,
		OP_AND   = 6'd29,
		OP_ORR   = 6'd30,
		OP_XOR   = 6'd31,
		OP_INV   = 6'd32,
		OP_INV_M = 6'd33,
		OP_LAN   = 6'd34,
		OP_LOR   = 6'd35,
		OP_LIN   = 6'd36,
		OP_LIN_M = 6'd37,
		OP_LES   = 6'd38,
		OP_GRE   = 6'd40,
		OP_EQU   = 6'd42,
		OP_SHL   = 6'd43,
		OP_SHR   = 6'd44,
		OP_SRS   = 6'd45
	} alu_op_e;

	// Which unit owns an opcode
	typedef enum logic [1:0] {
		GRP_ARITH,
		GRP_LOGIC,
		GRP_CMP_SHIFT,
		GRP_NONE      // Invalid code, result is zero
	} alu_group_e;

	// ******************** Group lookup
	function automatic alu_group_e alu_op_group(input alu_op_e op);
		case (op)
			OP_ADD, OP_MLT, OP_DIV, OP_MOD, OP_SGN,
			OP_NEG, OP_NEG_M, OP_ABS, OP_ABS_M,
			OP_PST, OP_PST_M, OP_NRM, OP_NRM_M: return GRP_ARITH;
			OP_NOP, OP_LOD, OP_AND, OP_ORR, OP_XOR, OP_INV, OP_INV_M,
			OP_LAN, OP_LOR, OP_LIN, OP_LIN_M: return GRP_LOGIC;
			OP_LES, OP_GRE, OP_EQU,
			OP_SHL, OP_SHR, OP_SRS: return GRP_CMP_SHIFT;
			default: return GRP_NONE;
		endcase
	endfunction

endpackage

// ==== hdl/alu_arith.sv ====
// ********************
// Purely combinational; multiply and divide are full single-cycle arrays
// DIV by zero gives all ones, MOD by zero gives in1
// GAIN must be nonzero and fit in WIDTH bits
// ********************

`timescale 1ns/1ps

module alu_arith import alu_pkg::*; #(
	parameter int WIDTH = DEFAULT_WIDTH,
	parameter int GAIN  = 64
) (
	input  alu_op_e                 op,
	input  logic signed [WIDTH-1:0] in1,          // Memory operand
	input  logic signed [WIDTH-1:0] in2,          // Accumulator operand
	output logic        [WIDTH-1:0] arith_result
);

	localparam logic signed [WIDTH-1:0] GAIN_W = WIDTH'(GAIN); // Divisor for NRM

	// ******************** Two-operand results
	logic signed [WIDTH-1:0] sum;
	logic signed [WIDTH-1:0] prod;
	logic signed [WIDTH-1:0] quot;
	logic signed [WIDTH-1:0] rem;
	logic signed [WIDTH-1:0] sgn_val;
	logic                    div_zero;

	// ******************** One-operand results
	logic                    use_in1;             // _M variant selected
	logic signed [WIDTH-1:0] un_in;
	logic signed [WIDTH-1:0] un_neg;
	logic signed [WIDTH-1:0] un_abs;
	logic signed [WIDTH-1:0] un_pst;
	logic signed [WIDTH-1:0] un_nrm;

	assign sum  = in1 + in2;
	assign prod = in1 * in2;                      // Low half of product kept

	// Divider guarded so a zero divisor never reaches the result
	assign div_zero = (in2 == '0);
	assign quot     = div_zero ? $signed({WIDTH{1'b1}}) : in1 / in2; // Truncates toward zero
	assign rem      = div_zero ? in1 : in1 % in2; // Sign follows in1

	// in2 takes the sign of in1
	assign sgn_val = (in1[WIDTH-1] == in2[WIDTH-1]) ? in2 : -in2;

	// Shared unary datapath, operand picked by the _M variants
	assign use_in1 = (op == OP_NEG_M) || (op == OP_ABS_M) ||
	                 (op == OP_PST_M) || (op == OP_NRM_M);
	assign un_in   = use_in1 ? in1 : in2;

	assign un_neg = -un_in;                       // Most negative wraps to itself
	assign un_abs = un_in[WIDTH-1] ? -un_in : un_in;
	assign un_pst = un_in[WIDTH-1] ? '0 : un_in;  // Clamp at zero
	assign un_nrm = un_in / GAIN_W;               // Signed, toward zero

	// ******************** Result select
	always_comb begin
		case (op)
			OP_ADD:             arith_result = sum;
			OP_MLT:             arith_result = prod;
			OP_DIV:             arith_result = quot;
			OP_MOD:             arith_result = rem;
			OP_SGN:             arith_result = sgn_val;
			OP_NEG, OP_NEG_M:   arith_result = un_neg;
			OP_ABS, OP_ABS_M:   arith_result = un_abs;
			OP_PST, OP_PST_M:   arith_result = un_pst;
			OP_NRM, OP_NRM_M:   arith_result = un_nrm;
			default:            arith_result = '0;    // Not an arithmetic op
		endcase
	end

endmodule

// ==== hdl/alu_logic.sv ====
// ********************
// Conditional ops treat any nonzero operand as true
// They return 1 or 0 in the low bit
// ********************

`timescale 1ns/1ps

module alu_logic import alu_pkg::*; #(
	parameter int WIDTH = DEFAULT_WIDTH
) (
	input  alu_op_e          op,
	input  logic [WIDTH-1:0] in1,
	input  logic [WIDTH-1:0] in2,
	output logic [WIDTH-1:0] logic_result
);

	logic in1_true;  // Operand nonzero
	logic in2_true;
	logic cond;      // Conditional op outcome

	assign in1_true = |in1;
	assign in2_true = |in2;

	// ******************** Conditional ops
	always_comb begin
		case (op)
			OP_LAN:   cond = in1_true && in2_true;
			OP_LOR:   cond = in1_true || in2_true;
			OP_LIN:   cond = !in2_true;
			OP_LIN_M: cond = !in1_true;
			default:  cond = 1'b0;
		endcase
	end

	// ******************** Result select
	always_comb begin
		case (op)
			OP_NOP:   logic_result = in2;             // Accumulator through
			OP_LOD:   logic_result = in1;             // Memory through
			OP_AND:   logic_result = in1 & in2;
			OP_ORR:   logic_result = in1 | in2;
			OP_XOR:   logic_result = in1 ^ in2;
			OP_INV:   logic_result = ~in2;
			OP_INV_M: logic_result = ~in1;
			OP_LAN, OP_LOR, OP_LIN, OP_LIN_M: begin
				logic_result = {{(WIDTH-1){1'b0}}, cond}; // Zero-extended flag
			end
			default:  logic_result = '0;
		endcase
	end

endmodule

// ==== hdl/alu_compare_shift.sv ====
// ********************
// Comparisons are signed, shift amount is in2 read as unsigned
// Amounts of WIDTH or more flush to zero, or to sign fill for SRS
// ********************

`timescale 1ns/1ps

module alu_compare_shift import alu_pkg::*; #(
	parameter int WIDTH = DEFAULT_WIDTH
) (
	input  alu_op_e                 op,
	input  logic signed [WIDTH-1:0] in1,
	input  logic signed [WIDTH-1:0] in2,
	output logic        [WIDTH-1:0] cmp_shift_result
);

	localparam int SHW = $clog2(WIDTH);           // Bits of an in-range amount

	logic                    cmp_flag;
	logic                    big_shift;           // Amount out of range
	logic        [SHW-1:0]   shamt;
	logic signed [WIDTH-1:0] sign_fill;

	assign big_shift = ($unsigned(in2) >= WIDTH);
	assign shamt     = in2[SHW-1:0];
	assign sign_fill = {WIDTH{in1[WIDTH-1]}};

	// ******************** Comparisons
	always_comb begin
		case (op)
			OP_LES:  cmp_flag = (in1 <  in2);       // Both signed
			OP_GRE:  cmp_flag = (in1 >  in2);
			OP_EQU:  cmp_flag = (in1 == in2);
			default: cmp_flag = 1'b0;
		endcase
	end

	// ******************** Result select
	always_comb begin
		case (op)
			OP_LES, OP_GRE, OP_EQU: cmp_shift_result = {{(WIDTH-1){1'b0}}, cmp_flag};
			OP_SHL: cmp_shift_result = big_shift ? '0 : in1 << shamt;
			OP_SHR: cmp_shift_result = big_shift ? '0 : in1 >> shamt;      // Zero fill
			OP_SRS: cmp_shift_result = big_shift ? sign_fill : in1 >>> shamt;
			default: cmp_shift_result = '0;
		endcase
	end

endmodule

// ==== hdl/alu_result_stage.sv ====
// ********************
// Single output register, loaded every cycle, no enable
// Unknown opcodes register zero
// ********************

`timescale 1ns/1ps

module alu_result_stage import alu_pkg::*; #(
	parameter int WIDTH = DEFAULT_WIDTH
) (
	input  logic             clk,
	input  logic             reset,
	input  alu_op_e          op,
	input  logic [WIDTH-1:0] arith_result,
	input  logic [WIDTH-1:0] logic_result,
	input  logic [WIDTH-1:0] cmp_shift_result,
	output logic [WIDTH-1:0] out
);

	alu_group_e       grp;      // Unit that owns op
	logic [WIDTH-1:0] next_out; // Value loaded at the next edge

	assign grp = alu_op_group(op);

	// ******************** Group mux
	// Units already zero their bus for foreign ops,
	// the choice between units is made only here
	always_comb begin
		case (grp)
			GRP_ARITH:     next_out = arith_result;
			GRP_LOGIC:     next_out = logic_result;
			GRP_CMP_SHIFT: next_out = cmp_shift_result;
			default:       next_out = '0; // GRP_NONE
		endcase
	end

	// ******************** Output register
	always_ff @(posedge clk) begin
		if (reset) begin
			out <= '0;
		end else begin
			out <= next_out;   // One cycle for every op
		end
	end

endmodule

// ==== hdl/alu.sv ====
// ********************
// Integer ALU, one cycle from op and operands to out
// A new op can be issued every cycle; no handshake
// in1 is the memory operand, in2 the accumulator
// ********************

`timescale 1ns/1ps

module alu import alu_pkg::*; #(
	parameter int WIDTH = DEFAULT_WIDTH,
	parameter int GAIN  = 64            // NRM divisor, must be nonzero
) (
	input  logic                    clk,
	input  logic                    reset,
	input  alu_op_e                 op,
	input  logic signed [WIDTH-1:0] in1,
	input  logic signed [WIDTH-1:0] in2,
	output logic        [WIDTH-1:0] out
);

	// ******************** Unit result buses
	logic [WIDTH-1:0] arith_result;
	logic [WIDTH-1:0] logic_result;
	logic [WIDTH-1:0] cmp_shift_result;

	// Add, multiply, divide and the unary arithmetic ops
	alu_arith #(
		.WIDTH (WIDTH),
		.GAIN  (GAIN)
	) i_alu_arith (
		.op           (op),
		.in1          (in1),
		.in2          (in2),
		.arith_result (arith_result)
	);

	// Pass, bitwise and conditional ops
	alu_logic #(
		.WIDTH (WIDTH)
	) i_alu_logic (
		.op           (op),
		.in1          (in1),
		.in2          (in2),
		.logic_result (logic_result)
	);

	// Signed compares and shifts
	alu_compare_shift #(
		.WIDTH (WIDTH)
	) i_alu_compare_shift (
		.op               (op),
		.in1              (in1),
		.in2              (in2),
		.cmp_shift_result (cmp_shift_result)
	);

	// ******************** Output
	alu_result_stage #(
		.WIDTH (WIDTH)
	) i_alu_result_stage (
		.clk              (clk),
		.reset            (reset),
		.op               (op),
		.arith_result     (arith_result),
		.logic_result     (logic_result),
		.cmp_shift_result (cmp_shift_result),
		.out              (out)
	);

endmodule

// ==== dv/alu_tb_model.svh ====
// ********************
// Expected ALU result per opcode, included inside alu_tb
// Relies on the testbench WIDTH and GAIN; unknown codes give zero
// ********************

`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

function automatic logic [WIDTH-1:0] alu_model(
	input alu_op_e          op,
	input logic [WIDTH-1:0] a,  // Memory operand
	input logic [WIDTH-1:0] b   // Accumulator operand
);
	logic signed [WIDTH-1:0] sa;
	logic signed [WIDTH-1:0] sb;
	logic signed [WIDTH-1:0] mag;    // |in2|, wraps for the most negative value
	logic signed [WIDTH-1:0] x;      // Unary operand
	logic signed [WIDTH-1:0] gain_s;
	sa     = a;
	sb     = b;
	gain_s = GAIN;
	mag    = (sb < 0) ? -sb : sb;
	// _M variants read in1
	case (op)
		OP_NEG_M, OP_ABS_M, OP_PST_M, OP_NRM_M: x = sa;
		default:                                x = sb;
	endcase
	case (op)
		OP_NOP:           return b;
		OP_LOD:           return a;
		OP_ADD:           return a + b;
		OP_MLT:           return a * b;            // Low bits only
		OP_DIV: begin
			if (b == 0)
				return '1;
			return sa / sb;
		end
		OP_MOD: begin
			if (b == 0)
				return a;
			return sa % sb;
		end
		OP_SGN:           return (sa < 0) ? -mag : mag;
		OP_NEG, OP_NEG_M: return -x;
		OP_ABS, OP_ABS_M: return (x < 0) ? -x : x;
		OP_PST, OP_PST_M: return (x < 0) ? 0 : x;
		OP_NRM, OP_NRM_M: return x / gain_s;      // Toward zero
		OP_AND:           return a & b;
		OP_ORR:           return a | b;
		OP_XOR:           return a ^ b;
		OP_INV:           return ~b;
		OP_INV_M:         return ~a;
		OP_LAN:           return WIDTH'((a != 0) && (b != 0));
		OP_LOR:           return WIDTH'((a != 0) || (b != 0));
		OP_LIN:           return WIDTH'(b == 0);
		OP_LIN_M:         return WIDTH'(a == 0);
		OP_LES:           return WIDTH'(sa < sb);
		OP_GRE:           return WIDTH'(sa > sb);
		OP_EQU:           return WIDTH'(sa == sb);
		OP_SHL:           return a << b;           // Large amounts flush out
		OP_SHR:           return a >> b;
		OP_SRS:           return sa >>> b;         // Sign fill past WIDTH
		default:          return '0;
	endcase
endfunction

`endif

// ==== dv/alu_tb.sv ====
// ********************
// Self-checking bench for alu at WIDTH 32, GAIN 64
// out is checked at the falling edge against the op of the previous cycle
// Stops at the first mismatch or at the cycle limit
// ********************

`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

	localparam int WIDTH      = 32;
	localparam int GAIN       = 64;
	localparam int MAX_CYCLES = 2000;           // Whole-run limit
	localparam logic [WIDTH-1:0] MIN_NEG = {1'b1, {(WIDTH-1){1'b0}}};
	localparam logic [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};

	logic                    clk;
	logic                    reset;
	alu_op_e                 op;
	logic signed [WIDTH-1:0] in1;
	logic signed [WIDTH-1:0] in2;
	logic        [WIDTH-1:0] out;

	// ******************** Inputs of the last edge
	alu_op_e          prev_op;
	logic [WIDTH-1:0] prev_in1;
	logic [WIDTH-1:0] prev_in2;
	string            cur_test;
	string            prev_test;
	logic             reset_seen = 1'b0;    // Reset was high at the last edge
	logic             live_seen  = 1'b0;    // Last edge loaded a real result
	logic [WIDTH-1:0] exp_out;

	alu_op_e op_list [30] = '{
		OP_NOP, OP_LOD, OP_ADD, OP_MLT, OP_DIV, OP_MOD, OP_SGN,
		OP_NEG, OP_NEG_M, OP_ABS, OP_ABS_M, OP_PST, OP_PST_M, OP_NRM, OP_NRM_M,
		OP_AND, OP_ORR, OP_XOR, OP_INV, OP_INV_M,
		OP_LAN, OP_LOR, OP_LIN, OP_LIN_M,
		OP_LES, OP_GRE, OP_EQU, OP_SHL, OP_SHR, OP_SRS
	};

	`include "alu_tb_model.svh"

	alu #(
		.WIDTH (WIDTH),
		.GAIN  (GAIN)
	) i_alu (
		.clk   (clk),
		.reset (reset),
		.op    (op),
		.in1   (in1),
		.in2   (in2),
		.out   (out)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;                     // 4 ns period

	always @(posedge clk) begin
		prev_op    <= op;
		prev_in1   <= in1;
		prev_in2   <= in2;
		prev_test  <= cur_test;
		reset_seen <= reset;
		live_seen  <= !reset;
	end

	assign exp_out = alu_model(prev_op, prev_in1, prev_in2);

	// ******************** Checks
	// Falling edge, inputs and out both settled
	reset_clears: assert property (@(negedge clk) reset_seen |-> (out == '0))
		else report_mismatch("reset", '0, out);
	result_matches: assert property (@(negedge clk) live_seen |-> (out == exp_out))
		else report_mismatch(prev_test, exp_out, out);

	task automatic report_mismatch(
		input string            name,
		input logic [WIDTH-1:0] expected,
		input logic [WIDTH-1:0] actual
	);
		$display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
		$display("Verification failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	// One op per cycle, just after the rising edge
	task automatic apply(
		input alu_op_e          code,
		input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b,
		input string            name
	);
		@(posedge clk);
		#0.5;
		op       = code;
		in1      = a;
		in2      = b;
		cur_test = name;
	endtask

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		while (reset_seen) begin
			@(negedge clk);
			cycles++;
			if (cycles > 10) begin
				$display("Reset never released within 10 cycles");
				$display("Verification failed");
				$fatal(1, "reset wait timed out");
			end
		end
	endtask

	function automatic bit is_listed(input logic [OP_BITS-1:0] code);
		foreach (op_list[i]) begin
			if (op_list[i] == code)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// ******************** Watchdog
	initial begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("Run went past %0d cycles without finishing", MAX_CYCLES);
		$display("Verification failed");
		$fatal(1, "cycle limit reached");
	end

	// ******************** Stimulus
	initial begin
		logic [WIDTH-1:0] a;
		logic [WIDTH-1:0] b;
		void'($urandom(32'h2779a755));
		reset    = 1'b1;
		op       = OP_LOD;                    // Nonzero unless reset clears out
		in1      = 32'h5a5a_c3c3;
		in2      = '0;
		cur_test = "reset";
		repeat (2) @(posedge clk);
		#0.5;
		reset = 1'b0;
		op    = OP_NOP;
		in1   = '0;
		wait_reset_done();

		// Random sweep, odd rounds use tiny operands to hit zero tests
		for (int r = 0; r < 8; r++) begin
			foreach (op_list[i]) begin
				a = (r % 2) ? WIDTH'($urandom_range(0, 4)) - 2 : $urandom;
				b = (r % 2) ? WIDTH'($urandom_range(0, 4)) - 2 : $urandom;
				apply(op_list[i], a, b, "random sweep");
			end
		end

		// Arithmetic corners
		apply(OP_DIV, 32'd100, '0, "div by zero");
		apply(OP_MOD, -32'sd77, '0, "mod by zero");
		apply(OP_DIV, -32'sd7, 32'sd2, "div negative");
		apply(OP_MOD, -32'sd7, 32'sd2, "mod negative");
		apply(OP_NRM, '0, -32'sd100, "nrm negative");
		apply(OP_NRM, '0, -32'sd63, "nrm small negative");
		apply(OP_NRM_M, -32'sd64, '0, "nrm_m exact");
		apply(OP_NRM_M, -32'sd1000, '0, "nrm_m negative");
		apply(OP_ABS, '0, MIN_NEG, "abs most negative");
		apply(OP_ABS_M, MIN_NEG, '0, "abs_m most negative");
		apply(OP_PST, '0, MIN_NEG, "pst most negative");
		apply(OP_PST_M, MIN_NEG, '0, "pst_m most negative");
		apply(OP_NEG, '0, MIN_NEG, "neg most negative");

		// Signed compares, mixed signs
		apply(OP_LES, -32'sd1, 32'sd1, "les mixed sign");
		apply(OP_GRE, -32'sd1, 32'sd1, "gre mixed sign");
		apply(OP_GRE, 32'sd5, -32'sd5, "gre positive");
		apply(OP_LES, MIN_NEG, MAX_POS, "les extremes");
		apply(OP_EQU, -32'sd3, -32'sd3, "equ negative");

		// Shift amounts around WIDTH
		apply(OP_SHL, 32'h8000_0001, 32'd0, "shl by 0");
		apply(OP_SHL, 32'h8000_0001, 32'd31, "shl by 31");
		apply(OP_SHL, 32'h8000_0001, 32'd32, "shl by 32");
		apply(OP_SHL, 32'h8000_0001, 32'hffff_ffff, "shl huge");
		apply(OP_SHR, 32'h8000_0001, 32'd31, "shr by 31");
		apply(OP_SHR, 32'h8000_0001, 32'd33, "shr by 33");
		apply(OP_SRS, 32'h8000_0010, 32'd0, "srs by 0");
		apply(OP_SRS, 32'h8000_0010, 32'd31, "srs by 31");
		apply(OP_SRS, 32'h8000_0010, 32'd32, "srs sign fill");
		apply(OP_SRS, 32'h8000_0010, 32'h8000_0000, "srs huge");
		apply(OP_SRS, 32'h4000_0000, 32'd40, "srs positive fill");

		// Every code outside the map
		for (int c = 0; c < (1 << OP_BITS); c++) begin
			if (!is_listed(OP_BITS'(c)))
				apply(alu_op_e'(OP_BITS'(c)), $urandom, $urandom, "invalid opcode");
		end

		apply(OP_NOP, '0, '0, "drain");
		repeat (2) @(negedge clk);         // Last op seen at out
		@(posedge clk);                    // Final falling-edge check has run
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+dv
hdl/alu_pkg.sv
hdl/alu_arith.sv
hdl/alu_logic.sv
hdl/alu_compare_shift.sv
hdl/alu_result_stage.sv
hdl/alu.sv
dv/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - target: any(rtl, test)
    files:
      - hdl/alu_pkg.sv
      - hdl/alu_arith.sv
      - hdl/alu_logic.sv
      - hdl/alu_compare_shift.sv
      - hdl/alu_result_stage.sv
      - hdl/alu.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/alu_tb.sv
